// ==== src/launcher_config.svh ====
`ifndef LAUNCHER_CONFIG_SVH
`define LAUNCHER_CONFIG_SVH

// ADC frame rate
`define ADC_CYCLES            16   // Clocks per conversion

// Fire button debounce
`define DB_PRESS_CYCLES       50   // High time before a press counts
`define DB_PULSE_CYCLES       100  // Fire pulse length
`define DB_RELEASE_CYCLES     200  // Low time before re-arm

// Firing window
`define FIRE_CYCLES           3000 // Whole window
`define SETPOINT_STEP_CYCLES  1000 // Step to high current

// Buck pulse limits
`define PWM_MIN_ON            32
`define PWM_MAX_ON            768
`define PWM_MIN_OFF           192

// Current setpoints in DN, 205 DN/A
`define I_SET_LOW             410  // 2 A
`define I_SET_HIGH            820  // 4 A
`define I_HYST                20

// Arm hysteresis on cap voltage, about 0.2 V/DN
`define V_ARM_ON              1496 // 300 V
`define V_ARM_OFF             249  // 50 V

`define BLINK_BIT             6    // Charge blink rate

`endif

// ==== src/adc_pkg.sv ====
package adc_pkg;

	// Native converter word, sign on top, magnitude bits inverted
	typedef logic [11:0] adc_code_t;

	typedef logic [10:0] adc_mag_t; // Clipped to positive

	// One frame from both dual-channel converters
	typedef struct packed {
		adc_code_t a0;     // Output current
		adc_code_t a1;     // Capacitor voltage
		adc_code_t b0;
		adc_code_t b1;
		logic      strobe; // New frame this cycle
	} adc_frame_t;

	// Negative readings clip to zero
	function automatic adc_mag_t to_magnitude(input adc_code_t code);
		if (code[11])
			return '0;
		return ~code[10:0];
	endfunction

endpackage

// ==== src/launch_ctrl_pkg.sv ====
package launch_ctrl_pkg;

	// Fire button debounce
	typedef enum logic [2:0] {
		DB_IDLE,
		DB_WAIT_PRESS,   // Button high, not yet trusted
		DB_PULSE,        // Fire pulse out
		DB_HELD,         // Still pressed after the pulse
		DB_WAIT_RELEASE  // Low, waiting out bounce
	} debounce_state_e;

	// Launch sequence, one way only until reset
	typedef enum logic [1:0] {
		CHARGING,
		READY,
		FIRING,
		SPENT
	} charge_state_e;

	// Buck pulse generator
	typedef enum logic [1:0] {
		PWM_IDLE,
		PWM_ON,
		PWM_OFF
	} pwm_state_e;

	// Sequencer to pulse generator
	typedef struct packed {
		logic active;        // Firing window open
		logic high_setpoint; // Second half of the window
		logic done;          // Window over, cap dumped
	} fire_status_t;

endpackage

// ==== src/adc_receiver.sv ====
`timescale 1ns/1ps
`include "launcher_config.svh"

module adc_receiver (
	input  logic               clk,
	input  logic               reset,
	output logic               o_ad_cs,
	input  logic [1:0]         i_ad_sdata_a, // [0] a0, [1] a1
	input  logic [1:0]         i_ad_sdata_b, // [0] b0, [1] b1
	output adc_pkg::adc_frame_t o_adc
);
	import adc_pkg::*;

	localparam int CNT_W = $clog2(`ADC_CYCLES);

	logic [CNT_W-1:0] sample_div;
	logic [14:0]      cs_delay;   // Bit k set k+1 edges after cs
	logic [11:0]      load;       // Walking bit strobe, MSB first
	adc_code_t        ld_a0, ld_a1, ld_b0, ld_b1;

	//////////////////////////////
	// Chip select
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_div <= CNT_W'(`ADC_CYCLES - 1);
		end else begin
			sample_div <= (sample_div == '0) ? CNT_W'(`ADC_CYCLES - 1)
			                                 : sample_div - 1'b1;
		end
	end

	assign o_ad_cs = (sample_div == '0); // One cycle per frame

	// Delay chain times everything off the cs edge
	always_ff @(posedge clk) begin
		if (reset) begin
			cs_delay <= '0;
			load     <= '0;
		end else begin
			cs_delay <= {cs_delay[13:0], o_ad_cs};
			load     <= {cs_delay[0], load[11:1]}; // MSB strobe lands on 3rd edge
		end
	end

	//////////////////////////////
	// Serial capture
	//////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < 12; i++) begin
			if (load[i]) begin
				ld_a0[i] <= i_ad_sdata_a[0];
				ld_a1[i] <= i_ad_sdata_a[1];
				ld_b0[i] <= i_ad_sdata_b[0];
				ld_b1[i] <= i_ad_sdata_b[1];
			end
		end
	end

	// All four channels copied out together, 16 edges after cs
	always_ff @(posedge clk) begin
		if (reset) begin
			o_adc <= '0;
		end else begin
			o_adc.strobe <= cs_delay[14];
			if (cs_delay[14]) begin
				o_adc.a0 <= ld_a0;
				o_adc.a1 <= ld_a1;
				o_adc.b0 <= ld_b0;
				o_adc.b1 <= ld_b1;
			end
		end
	end

endmodule

// ==== src/fire_debounce.sv ====
`timescale 1ns/1ps
`include "launcher_config.svh"

module fire_debounce (
	input  logic clk,
	input  logic reset,
	input  logic i_button,
	output logic o_fire_pulse
);
	import launch_ctrl_pkg::*;

	localparam int PW = $clog2(`DB_PRESS_CYCLES + `DB_PULSE_CYCLES);
	localparam int RW = $clog2(`DB_RELEASE_CYCLES + 1);

	// The state that first sees the level counts as its first cycle
	localparam logic [PW-1:0] PRESS_LAST   = PW'(`DB_PRESS_CYCLES - 2);
	localparam logic [PW-1:0] PULSE_LAST   = PW'(`DB_PULSE_CYCLES - 1);
	localparam logic [RW-1:0] RELEASE_LAST = RW'(`DB_RELEASE_CYCLES - 2);

	logic [1:0]      meta;
	logic            btn;          // Synchronized button
	debounce_state_e state;
	logic [PW-1:0]   press_cnt;    // Press qualify, then pulse length
	logic [RW-1:0]   rel_cnt;

	always_ff @(posedge clk) begin
		meta <= {meta[0], i_button};
	end
	assign btn = meta[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= DB_IDLE;
			press_cnt <= '0;
			rel_cnt   <= '0;
		end else begin
			case (state)
				DB_IDLE: begin
					press_cnt <= '0;
					if (btn)
						state <= DB_WAIT_PRESS;
				end
				DB_WAIT_PRESS: begin
					if (!btn) begin
						state <= DB_IDLE; // Glitch, drop it
					end else if (press_cnt == PRESS_LAST) begin
						state     <= DB_PULSE;
						press_cnt <= '0;
					end else begin
						press_cnt <= press_cnt + 1'b1;
					end
				end
				DB_PULSE: begin
					if (press_cnt == PULSE_LAST)
						state <= DB_HELD;
					else
						press_cnt <= press_cnt + 1'b1;
				end
				DB_HELD: begin
					rel_cnt <= '0;
					if (!btn)
						state <= DB_WAIT_RELEASE;
				end
				DB_WAIT_RELEASE: begin
					if (btn) begin
						state <= DB_HELD;   // Bounce, start over
					end else if (rel_cnt == RELEASE_LAST) begin
						state <= DB_IDLE;
					end else begin
						rel_cnt <= rel_cnt + 1'b1;
					end
				end
				default: state <= DB_IDLE;
			endcase
		end
	end

	assign o_fire_pulse = (state == DB_PULSE);

endmodule

// ==== src/launch_sequencer.sv ====
`timescale 1ns/1ps
`include "launcher_config.svh"

module launch_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_fire_pulse,
	input  logic                        i_lt3420_done,
	input  adc_pkg::adc_frame_t         i_adc,
	output launch_ctrl_pkg::fire_status_t o_status,
	output logic                        o_lt3420_charge,
	output logic                        o_dump,
	output logic                        o_arm_led
);
	import adc_pkg::*;
	import launch_ctrl_pkg::*;

	localparam int WW = $clog2(`FIRE_CYCLES);

	charge_state_e        state;
	logic [WW-1:0]        win_cnt;   // Cycles into the firing window
	adc_mag_t             vcap;
	logic                 cap_charged;
	logic [`BLINK_BIT:0]  free_cnt;

	//////////////////////////////
	// Launch sequence
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= CHARGING;
			win_cnt <= '0;
		end else begin
			case (state)
				CHARGING: if (i_lt3420_done) state <= READY; // Early presses ignored
				READY: begin
					win_cnt <= '0;
					if (i_fire_pulse)
						state <= FIRING;
				end
				FIRING: begin
					if (win_cnt == WW'(`FIRE_CYCLES - 1))
						state <= SPENT;
					else
						win_cnt <= win_cnt + 1'b1;
				end
				SPENT: state <= SPENT;   // Held until reset
				default: state <= CHARGING;
			endcase
		end
	end

	always_comb begin
		o_status.active        = (state == FIRING);
		o_status.high_setpoint = (state == FIRING) && (win_cnt >= WW'(`SETPOINT_STEP_CYCLES));
		o_status.done          = (state == SPENT);
	end

	assign o_dump          = o_status.done;        // Bleed the cap after firing
	assign o_lt3420_charge = (state == CHARGING);  // Charger off once done or firing

	//////////////////////////////
	// Arm LED
	//////////////////////////////
	assign vcap = to_magnitude(i_adc.a1);

	// 300 V on, 50 V off, only at a new sample
	always_ff @(posedge clk) begin
		if (reset) begin
			cap_charged <= 1'b0;
		end else if (i_adc.strobe) begin
			if (vcap > adc_mag_t'(`V_ARM_ON))
				cap_charged <= 1'b1;
			else if (vcap < adc_mag_t'(`V_ARM_OFF))
				cap_charged <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			free_cnt <= '0;
		else
			free_cnt <= free_cnt + 1'b1;
	end

	assign o_arm_led = cap_charged | (o_lt3420_charge & free_cnt[`BLINK_BIT]); // Blink while charging

endmodule

// ==== src/current_pwm.sv ====
`timescale 1ns/1ps
`include "launcher_config.svh"

module current_pwm (
	input  logic                          clk,
	input  logic                          reset,
	input  launch_ctrl_pkg::fire_status_t i_status,
	input  adc_pkg::adc_frame_t           i_adc,
	output logic                          o_pwm
);
	import adc_pkg::*;
	import launch_ctrl_pkg::*;

	localparam int TW = $clog2(`PWM_MAX_ON + 1);

	localparam logic [TW-1:0] MIN_ON  = TW'(`PWM_MIN_ON);
	localparam logic [TW-1:0] MAX_ON  = TW'(`PWM_MAX_ON);
	localparam logic [TW-1:0] MIN_OFF = TW'(`PWM_MIN_OFF);

	pwm_state_e     state;
	logic [TW-1:0]  timer;     // On time, or off time saturating at MIN_OFF
	adc_mag_t       i_out;
	adc_mag_t       i_set;
	adc_mag_t       i_lo;
	adc_mag_t       i_hi;

	//////////////////////////////
	// Setpoint and thresholds
	//////////////////////////////
	assign i_out = to_magnitude(i_adc.a0);
	assign i_set = i_status.high_setpoint ? adc_mag_t'(`I_SET_HIGH) : adc_mag_t'(`I_SET_LOW);
	assign i_lo  = i_set - adc_mag_t'(`I_HYST);  // Start below this
	assign i_hi  = i_set + adc_mag_t'(`I_HYST);  // Stop above this

	//////////////////////////////
	// Pulse generator
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= PWM_IDLE;
			timer <= MIN_OFF;   // No earlier pulse to wait for
		end else begin
			case (state)
				PWM_IDLE: begin
					if (timer < MIN_OFF)
						timer <= timer + 1'b1;
					if (i_status.active)
						state <= PWM_OFF;
				end
				PWM_OFF: begin
					if (!i_status.active) begin
						state <= PWM_IDLE;
					end else if (timer >= MIN_OFF && i_out < i_lo) begin
						state <= PWM_ON;    // Coil current sagged
						timer <= TW'(1);
					end else if (timer < MIN_OFF) begin
						timer <= timer + 1'b1;
					end
				end
				PWM_ON: begin
					if (!i_status.active) begin
						state <= PWM_IDLE;  // Window closed, cut at once
						timer <= TW'(1);
					end else if (timer >= MIN_ON && (i_out > i_hi || timer >= MAX_ON)) begin
						state <= PWM_OFF;
						timer <= TW'(1);
					end else begin
						timer <= timer + 1'b1;
					end
				end
				default: state <= PWM_IDLE;
			endcase
		end
	end

	// Drops in the same cycle the window closes
	assign o_pwm = (state == PWM_ON) && i_status.active;

endmodule

// ==== src/launcher_top.sv ====
`timescale 1ns/1ps

module launcher_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_fire_button,
	input  logic       i_lt3420_done,
	input  logic [1:0] i_ad_sdata_a,
	input  logic [1:0] i_ad_sdata_b,
	output logic       o_ad_cs,
	output logic       o_lt3420_charge,
	output logic       o_pwm,
	output logic       o_dump,
	output logic       o_arm_led
);
	import adc_pkg::*;
	import launch_ctrl_pkg::*;

	adc_frame_t   adc;         // Latest held samples
	logic         fire_pulse;
	fire_status_t status;

	adc_receiver u_adc (
		.clk          (clk),
		.reset        (reset),
		.o_ad_cs      (o_ad_cs),
		.i_ad_sdata_a (i_ad_sdata_a),
		.i_ad_sdata_b (i_ad_sdata_b),
		.o_adc        (adc)
	);

	fire_debounce u_debounce (
		.clk          (clk),
		.reset        (reset),
		.i_button     (i_fire_button),
		.o_fire_pulse (fire_pulse)
	);

	launch_sequencer u_sequencer (
		.clk             (clk),
		.reset           (reset),
		.i_fire_pulse    (fire_pulse),
		.i_lt3420_done   (i_lt3420_done),
		.i_adc           (adc),
		.o_status        (status),
		.o_lt3420_charge (o_lt3420_charge),
		.o_dump          (o_dump),
		.o_arm_led       (o_arm_led)
	);

	current_pwm u_pwm (
		.clk      (clk),
		.reset    (reset),
		.i_status (status),
		.i_adc    (adc),
		.o_pwm    (o_pwm)
	);

endmodule

// ==== sim/launcher_assertions.sv ====
`timescale 1ns/1ps

module launcher_assertions (
	input logic clk,
	input logic reset,
	input logic i_ad_cs,
	input logic i_pwm,
	input logic i_dump
);

	// Chip select is a one-cycle strobe
	cs_single: assert property (@(posedge clk) disable iff (reset) i_ad_cs |=> !i_ad_cs)
		else $error("o_ad_cs high two cycles in a row");

	// No buck drive once the cap is dumped
	pwm_off_dump: assert property (@(posedge clk) disable iff (reset) i_dump |-> !i_pwm)
		else $error("o_pwm high while o_dump is high");

	dump_held: assert property (@(posedge clk) disable iff (reset) i_dump |=> i_dump)
		else $error("o_dump fell before reset"); // Latched until reset

endmodule

bind launcher_top launcher_assertions u_assertions (
	.clk     (clk),
	.reset   (reset),
	.i_ad_cs (o_ad_cs),
	.i_pwm   (o_pwm),
	.i_dump  (o_dump)
);

// ==== sim/launcher_tb.sv ====
`timescale 1ns/1ps
`include "launcher_config.svh"

module launcher_tb;

	logic       clk;
	logic       reset;
	logic       i_fire_button;
	logic       i_lt3420_done;
	logic [1:0] i_ad_sdata_a = '0;   // Only the ADC model drives these
	logic [1:0] i_ad_sdata_b = '0;
	logic       o_ad_cs;
	logic       o_lt3420_charge;
	logic       o_pwm;
	logic       o_dump;
	logic       o_arm_led;

	logic [11:0] code_a0, code_a1, code_b0, code_b1;   // Set by the tests
	logic [11:0] frame_a0, frame_a1, frame_b0, frame_b1; // Held for one conversion
	logic        a0_noisy = 1'b0;    // Stuck current channel
	integer      seed = 32'h8b36629f;
	int          bit_pos = 15;        // Edges since cs, parked at 15

	int cycle = 0;
	int rise_cycles[$];   // Cycle of each o_pwm rise
	int widths[$];        // On time of each o_pwm pulse
	int on_len = 0;
	int off_len = 0;
	logic pwm_prev = 1'b0;
	logic seen_fall = 1'b0;
	int window_ref;       // First pulse of the firing window
	int dump_cycle;

	launcher_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	//////////////////////////////
	// Converter format helpers
	//////////////////////////////
	function automatic logic [11:0] mag_to_code(input logic [10:0] mag);
		return {1'b0, ~mag}; // Positive, magnitude inverted
	endfunction

	// Divider scale, V_ARM_ON DN at 300 V
	function automatic logic [10:0] volts_to_dn(input int volts);
		return 11'(volts * `V_ARM_ON / 300);
	endfunction

	//////////////////////////////
	// Serial ADC model
	//////////////////////////////
	always @(posedge clk) begin
		#1;
		if (o_ad_cs === 1'b1) begin
			bit_pos = 0;
			frame_a0 = a0_noisy ? mag_to_code(11'($unsigned($random(seed)) % 48)) : code_a0;
			frame_a1 = code_a1;
			frame_b0 = code_b0;
			frame_b1 = code_b1;
		end else if (bit_pos < 15) begin
			bit_pos++;
		end
		// MSB sampled on the 3rd edge after cs
		if (bit_pos >= 2 && bit_pos <= 13) begin
			i_ad_sdata_a = {frame_a1[13 - bit_pos], frame_a0[13 - bit_pos]};
			i_ad_sdata_b = {frame_b1[13 - bit_pos], frame_b0[13 - bit_pos]};
		end
	end

	//////////////////////////////
	// Checks and waits
	//////////////////////////////
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stop_with_failure($sformatf("mismatch at %0t: %s got %0d, expected %0d",
			$time, name, got, exp));
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1;   // Drive and sample off the edge
	endtask

	function automatic logic port_value(input string name);
		if (name == "o_ad_cs")
			return o_ad_cs;
		if (name == "o_lt3420_charge")
			return o_lt3420_charge;
		if (name == "o_pwm")
			return o_pwm;
		if (name == "o_dump")
			return o_dump;
		return o_arm_led;
	endfunction

	task automatic wait_for_level(input string name, input logic level, input int limit);
		int n = 0;
		while (port_value(name) !== level && n < limit) begin
			tick(1);
			n++;
		end
		assert (port_value(name) === level)
		else stop_with_failure($sformatf("timeout at %0t: %s did not reach %0b in %0d cycles",
			$time, name, level, limit));
	endtask

	task automatic hold_steady(input string name, input logic level, input int cycles);
		repeat (cycles) begin
			check_equal(name, port_value(name), level);
			tick(1);
		end
	endtask

	// Pulse width and gap limits, whole run
	always @(posedge clk) begin
		#1;
		if (o_pwm === 1'b1) begin
			if (!pwm_prev) begin
				if (seen_fall) begin
					assert (off_len >= `PWM_MIN_OFF)
					else stop_with_failure($sformatf(
						"mismatch at %0t: o_pwm off time got %0d, expected at least %0d",
						$time, off_len, `PWM_MIN_OFF));
				end
				rise_cycles.push_back(cycle);
				on_len = 0;
			end
			on_len++;
		end else begin
			if (pwm_prev) begin
				if (!o_dump) begin   // Window close may cut a pulse
					assert (on_len >= `PWM_MIN_ON && on_len <= `PWM_MAX_ON)
					else stop_with_failure($sformatf(
						"mismatch at %0t: o_pwm on time got %0d, expected %0d to %0d",
						$time, on_len, `PWM_MIN_ON, `PWM_MAX_ON));
				end
				widths.push_back(on_len);
				seen_fall = 1'b1;
				off_len = 0;
			end
			off_len++;
		end
		pwm_prev = o_pwm;
	end

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic check_reset_outputs();
		int gap;
		check_equal("o_lt3420_charge", o_lt3420_charge, 1);
		check_equal("o_pwm", o_pwm, 0);
		check_equal("o_dump", o_dump, 0);
		wait_for_level("o_ad_cs", 1'b1, `ADC_CYCLES + 4);
		repeat (3) begin
			gap = 0;
			do begin
				tick(1);
				gap++;
			end while (o_ad_cs !== 1'b1 && gap < 2 * `ADC_CYCLES);
			check_equal("o_ad_cs period", gap, `ADC_CYCLES);
		end
		// Blink while charging and not armed
		wait_for_level("o_arm_led", 1'b1, (1 << `BLINK_BIT) + 8);
		wait_for_level("o_arm_led", 1'b0, (1 << `BLINK_BIT) + 8);
	endtask

	task automatic arm_led_hysteresis();
		code_a1 = mag_to_code(volts_to_dn(350));
		i_lt3420_done = 1'b1;
		wait_for_level("o_lt3420_charge", 1'b0, 4);
		wait_for_level("o_arm_led", 1'b1, 3 * `ADC_CYCLES + 4);
		code_a1 = mag_to_code(volts_to_dn(200));   // Inside the band
		hold_steady("o_arm_led", 1'b1, 4 * `ADC_CYCLES);
		code_a1 = mag_to_code(volts_to_dn(30));
		wait_for_level("o_arm_led", 1'b0, 3 * `ADC_CYCLES + 4);
		code_a1 = mag_to_code(volts_to_dn(200));
		hold_steady("o_arm_led", 1'b0, 4 * `ADC_CYCLES);
	endtask

	task automatic glitch_rejection();
		a0_noisy = 1'b1;   // Low current, a window would pulse at once
		i_fire_button = 1'b1;
		tick(`DB_PRESS_CYCLES / 2);
		i_fire_button = 1'b0;
		hold_steady("o_pwm", 1'b0, `DB_PRESS_CYCLES + `DB_PULSE_CYCLES + `PWM_MIN_OFF);
		check_equal("o_pwm pulse count", rise_cycles.size(), 0);
	endtask

	task automatic pulse_limits();
		i_fire_button = 1'b1;
		tick(`DB_PRESS_CYCLES + 10);
		i_fire_button = 1'b0;
		// First pulse never reaches the setpoint
		wait_for_level("o_pwm", 1'b1, `DB_PULSE_CYCLES + `PWM_MIN_OFF);
		wait_for_level("o_pwm", 1'b0, `PWM_MAX_ON + 8);
		tick(1);
		window_ref = rise_cycles[0];
		check_equal("o_pwm on time", widths[0], `PWM_MAX_ON);
		// Overcurrent above the low setpoint only
		wait_for_level("o_pwm", 1'b1, `PWM_MIN_OFF + 8);
		a0_noisy = 1'b0;
		code_a0 = mag_to_code(11'(`I_SET_LOW + `I_HYST + 80));
		wait_for_level("o_pwm", 1'b0, `PWM_MAX_ON + 8);
		tick(1);
		assert (widths.size() == 2 && widths[1] < `PWM_MAX_ON)
		else stop_with_failure($sformatf("mismatch at %0t: o_pwm on time got %0d, expected below %0d",
			$time, widths[widths.size() - 1], `PWM_MAX_ON));
		code_a0 = mag_to_code(11'((`I_SET_LOW + `I_SET_HIGH) / 2)); // Between setpoints
	endtask

	task automatic high_setpoint_pulses();
		int margin = 4 * `ADC_CYCLES;   // Step plus ADC latency
		int from;
		int expected;
		int count = 0;
		from = window_ref + `SETPOINT_STEP_CYCLES + margin;
		expected = (`FIRE_CYCLES - `SETPOINT_STEP_CYCLES - margin) / (`PWM_MAX_ON + `PWM_MIN_OFF);
		wait_for_level("o_dump", 1'b1, `FIRE_CYCLES + 100);
		dump_cycle = cycle;
		foreach (rise_cycles[i])
			if (rise_cycles[i] >= from)
				count++;
		assert (count >= expected && count > 0)
		else stop_with_failure($sformatf(
			"mismatch at %0t: o_pwm pulses after step got %0d, expected at least %0d",
			$time, count, expected));
	endtask

	task automatic dump_latch();
		int pulses;
		int window_len;
		window_len = dump_cycle - window_ref;
		assert (window_len >= `FIRE_CYCLES - 8 && window_len <= `FIRE_CYCLES + 8)
		else stop_with_failure($sformatf("mismatch at %0t: o_dump delay got %0d, expected about %0d",
			$time, window_len, `FIRE_CYCLES));
		check_equal("o_pwm", o_pwm, 0);
		pulses = rise_cycles.size();
		code_a0 = mag_to_code(11'd0);   // A new window would pulse at once
		i_fire_button = 1'b1;   // Second press, should be ignored
		tick(`DB_PRESS_CYCLES + 10);
		i_fire_button = 1'b0;
		hold_steady("o_dump", 1'b1, `DB_PULSE_CYCLES + `PWM_MIN_OFF + 100);
		check_equal("o_pwm pulse count", rise_cycles.size(), pulses);
	endtask

	initial begin
		reset = 1'b1;
		i_fire_button = 1'b0;
		i_lt3420_done = 1'b0;
		code_a0 = mag_to_code(11'd0);
		code_a1 = mag_to_code(11'd0);
		code_b0 = mag_to_code(11'd100);   // Unused channels
		code_b1 = mag_to_code(11'd200);
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check_reset_outputs();
		arm_led_hysteresis();
		glitch_rejection();
		pulse_limits();
		high_setpoint_pulses();
		dump_latch();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+src
src/adc_pkg.sv
src/launch_ctrl_pkg.sv
src/adc_receiver.sv
src/fire_debounce.sv
src/launch_sequencer.sv
src/current_pwm.sv
src/launcher_top.sv
sim/launcher_assertions.sv
sim/launcher_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' list.f)

obj_dir/Vlauncher_tb: list.f src/launcher_config.svh $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module launcher_tb -o Vlauncher_tb

run: obj_dir/Vlauncher_tb
	./obj_dir/Vlauncher_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
